//--- hw/pmp_pkg.sv
// ********************
// Shared types and constants of the PMP retirement checker
// Four regions with G = 2 and mseccfg assumed zero
// pmpaddr values are word addresses of a 34-bit space
// ********************

package pmp_pkg;

  localparam int PMP_NUM_REGIONS = 4;
  localparam int PMP_GRANULARITY = 2;

  // CSR numbers that make up the PMP register range
  localparam logic [11:0] CSRADDR_PMPCFG0  = 12'h3A0;
  localparam logic [11:0] CSRADDR_PMPADDR0 = 12'h3B0;
  localparam logic [11:0] CSRADDR_PMP_LAST = 12'h3EF;
  localparam logic [11:0] CSRADDR_MSECCFG  = 12'h747;
  localparam logic [11:0] CSRADDR_MSECCFGH = 12'h757;

  localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

  typedef enum logic [1:0] {
    OFF   = 2'd0,
    TOR   = 2'd1,
    NA4   = 2'd2,
    NAPOT = 2'd3
  } pmp_mode_e;

  typedef enum logic [1:0] {
    U = 2'b00,
    M = 2'b11
  } priv_mode_e;

  typedef enum logic [1:0] {
    EXEC  = 2'd0,
    READ  = 2'd1,
    WRITE = 2'd2
  } pmp_acc_e;

  // Standard mcause exception codes
  typedef enum logic [5:0] {
    INSTR_ACC_FAULT = 6'd1,
    ILLEGAL_INSTR   = 6'd2,
    LOAD_ACC_FAULT  = 6'd5,
    STORE_ACC_FAULT = 6'd7
  } exc_cause_e;

  // Same bit order as one pmpcfg byte
  typedef struct packed {
    logic       lock;
    logic [1:0] zero;
    pmp_mode_e  mode;
    logic       exec;
    logic       write;
    logic       read;
  } pmp_cfg_t;

  typedef struct packed {
    pmp_cfg_t [PMP_NUM_REGIONS-1:0]          cfg;
    logic     [PMP_NUM_REGIONS-1:0][31:0]    addr;
  } pmp_csr_t;

  typedef struct packed {
    logic       valid;
    logic [31:0] insn;
    priv_mode_e mode;
    logic       trap;
    logic       exception;
    exc_cause_e cause;
    logic [31:0] pc;
    logic [31:0] mem_addr;
    logic [3:0] mem_rmask;
    logic [3:0] mem_wmask;
    logic       mprv;
    priv_mode_e mpp;
  } rvfi_retire_t;

  typedef struct packed {
    logic exec_notrap;
    logic exec_cause;
    logic data_notrap;
    logic data_cause;
    logic csr_umode;
    logic cfg_illegal;
    logic write_lost;
    logic lock_broken;
  } pmp_err_t;

endpackage

//--- hw/pmp_region_match.sv
// ********************
// Combinational PMP permission check for one access
// Lowest-numbered matching region wins
// Addresses above 4 GiB are not reachable from addr_i
// ********************

`timescale 1ns/1ns

module pmp_region_match (
  input  pmp_pkg::pmp_csr_t   csr_i,
  input  logic [31:0]         addr_i,
  input  pmp_pkg::pmp_acc_e   acc_i,
  input  pmp_pkg::priv_mode_e priv_i,
  output logic                allowed_o
);

  // Word address in the same units as pmpaddr
  logic [31:0] word_addr;
  logic [pmp_pkg::PMP_NUM_REGIONS-1:0] hit;
  logic [pmp_pkg::PMP_NUM_REGIONS-1:0] perm;

  assign word_addr = {2'b00, addr_i[31:2]};

  for (genvar i = 0; i < pmp_pkg::PMP_NUM_REGIONS; i++) begin : gen_region
    pmp_pkg::pmp_cfg_t cfg;
    logic [31:0]       lower;
    logic [31:0]       span;
    logic              tor_hit;
    logic              na4_hit;
    logic              napot_hit;

    assign cfg = csr_i.cfg[i];

    // TOR base is the previous pmpaddr, or zero for region 0
    if (i == 0) begin : gen_base_zero
      assign lower = '0;
    end else begin : gen_base_prev
      assign lower = csr_i.addr[i-1];
    end

    // Ones at the trailing-ones positions and the first zero above them
    assign span = csr_i.addr[i] ^ (csr_i.addr[i] + 32'd1);

    assign tor_hit   = (word_addr >= lower) && (word_addr < csr_i.addr[i]);
    assign na4_hit   = (word_addr == csr_i.addr[i]);
    assign napot_hit = ((word_addr ^ csr_i.addr[i]) & ~span) == '0;

    assign hit[i] = ((cfg.mode == pmp_pkg::TOR)   && tor_hit) ||
                    ((cfg.mode == pmp_pkg::NA4)   && na4_hit) ||
                    ((cfg.mode == pmp_pkg::NAPOT) && napot_hit);

    assign perm[i] = (acc_i == pmp_pkg::EXEC)  ? cfg.exec  :
                     (acc_i == pmp_pkg::READ)  ? cfg.read  :
                     (acc_i == pmp_pkg::WRITE) ? cfg.write : 1'b0;
  end

  // Walk downwards so the lowest matching region has the last word
  always_comb begin
    allowed_o = (priv_i == pmp_pkg::M);
    for (int i = pmp_pkg::PMP_NUM_REGIONS - 1; i >= 0; i--) begin
      if (hit[i]) begin
        if ((priv_i != pmp_pkg::M) || csr_i.cfg[i].lock) begin
          allowed_o = perm[i];
        end else begin
          allowed_o = 1'b1;
        end
      end
    end
  end

endmodule

//--- hw/pmp_cfg_legalize.sv
// ********************
// Checks that written pmpcfg bytes are already WARL-legal
// Assumes mseccfg is zero, so RLB and MML never apply
// ********************

`timescale 1ns/1ns

module pmp_cfg_legalize (
  input  pmp_pkg::pmp_csr_t rdata_i,
  input  pmp_pkg::pmp_csr_t wdata_i,
  input  pmp_pkg::pmp_csr_t wmask_i,
  output logic              illegal_o
);

  logic [pmp_pkg::PMP_NUM_REGIONS-1:0] bad;

  for (genvar i = 0; i < pmp_pkg::PMP_NUM_REGIONS; i++) begin : gen_cfg
    pmp_pkg::pmp_cfg_t prev;
    pmp_pkg::pmp_cfg_t attempt;
    pmp_pkg::pmp_cfg_t legal;

    assign prev = rdata_i.cfg[i];

    // Unmasked bits keep their previous value
    assign attempt = (wdata_i.cfg[i] & wmask_i.cfg[i]) | (rdata_i.cfg[i] & ~wmask_i.cfg[i]);

    always_comb begin
      legal = attempt;

      // RW=01 is reserved, the whole RWX field stays
      if (attempt.write && !attempt.read) begin
        legal.read  = prev.read;
        legal.write = prev.write;
        legal.exec  = prev.exec;
      end

      // NA4 does not exist once the grain is larger than 4 bytes
      if ((pmp_pkg::PMP_GRANULARITY >= 1) && (attempt.mode == pmp_pkg::NA4)) begin
        legal.mode = prev.mode;
      end

      if (prev.lock) begin
        legal = prev;
      end

      // Bits 6:5 are hardwired
      legal.zero = 2'b00;
    end

    assign bad[i] = (wmask_i.cfg[i] != '0) && (attempt != legal);
  end

  assign illegal_o = |bad;

endmodule

//--- hw/pmp_csr_history.sv
// ********************
// Compares each retirement's PMP CSRs with the previous retirement
// First retirement after reset raises no flag
// Address bits below G are not compared for write effect
// ********************

`timescale 1ns/1ns

module pmp_csr_history (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              valid_i,
  input  pmp_pkg::pmp_csr_t rdata_i,
  input  pmp_pkg::pmp_csr_t wdata_i,
  input  pmp_pkg::pmp_csr_t wmask_i,
  output logic              write_lost_o,
  output logic              lock_broken_o
);

  localparam int G = pmp_pkg::PMP_GRANULARITY;

  pmp_pkg::pmp_csr_t prev_rdata;
  pmp_pkg::pmp_csr_t prev_wdata;
  pmp_pkg::pmp_csr_t prev_wmask;
  pmp_pkg::pmp_csr_t expected;
  logic              have_prev;

  logic [pmp_pkg::PMP_NUM_REGIONS-1:0] lost;
  logic [pmp_pkg::PMP_NUM_REGIONS-1:0] locked_chg;
  logic [pmp_pkg::PMP_NUM_REGIONS-1:0] tor_chg;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      have_prev <= 1'b0;
    end else if (valid_i) begin
      have_prev <= 1'b1;
    end
  end

  // Snapshot of the last retirement with valid high
  always_ff @(posedge clk_i) begin
    if (valid_i) begin
      prev_rdata <= rdata_i;
      prev_wdata <= wdata_i;
      prev_wmask <= wmask_i;
    end
  end

  // What the previous retirement said the registers would become
  assign expected = (prev_wdata & prev_wmask) | (prev_rdata & ~prev_wmask);

  for (genvar i = 0; i < pmp_pkg::PMP_NUM_REGIONS; i++) begin : gen_entry
    assign lost[i] = (rdata_i.cfg[i] != expected.cfg[i]) ||
                     (rdata_i.addr[i][31:G] != expected.addr[i][31:G]);

    // A cleared lock bit shows up as a cfg change
    assign locked_chg[i] = prev_rdata.cfg[i].lock &&
                           ((rdata_i.cfg[i] != prev_rdata.cfg[i]) ||
                            (rdata_i.addr[i] != prev_rdata.addr[i]));

    if (i == 0) begin : gen_no_below
      assign tor_chg[i] = 1'b0;
    end else begin : gen_below
      assign tor_chg[i] = prev_rdata.cfg[i].lock &&
                          (prev_rdata.cfg[i].mode == pmp_pkg::TOR) &&
                          (rdata_i.addr[i-1][31:G] != prev_rdata.addr[i-1][31:G]);
    end
  end

  assign write_lost_o  = have_prev && (|lost);
  assign lock_broken_o = have_prev && (|(locked_chg | tor_chg));

  a_have_prev_sticky: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    have_prev |=> have_prev
  );

endmodule

//--- hw/pmp_verdict.sv
// ********************
// Turns permission results into registered error flags
// Flags appear one cycle after valid, zero otherwise
// ********************

`timescale 1ns/1ns

module pmp_verdict (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  pmp_pkg::rvfi_retire_t rvfi_i,
  input  logic                  is_mem_i,
  input  logic                  is_pmp_csr_i,
  input  logic                  instr_allowed_i,
  input  logic                  data_allowed_i,
  input  logic                  cfg_illegal_i,
  input  logic                  write_lost_i,
  input  logic                  lock_broken_i,
  output pmp_pkg::pmp_err_t     err_o
);

  pmp_pkg::pmp_err_t   err_d;
  pmp_pkg::exc_cause_e data_cause_exp;
  logic                is_exc;
  logic                data_denied;

  assign is_exc = rvfi_i.trap && rvfi_i.exception;

  // A fetch fault hides whatever the data side would have done
  assign data_denied = is_mem_i && !data_allowed_i && instr_allowed_i;

  assign data_cause_exp = (|rvfi_i.mem_wmask) ? pmp_pkg::STORE_ACC_FAULT
                                              : pmp_pkg::LOAD_ACC_FAULT;

  always_comb begin
    err_d = '0;

    err_d.exec_notrap = !instr_allowed_i && !rvfi_i.trap;
    err_d.exec_cause  = !instr_allowed_i && is_exc &&
                        (rvfi_i.cause != pmp_pkg::INSTR_ACC_FAULT);

    err_d.data_notrap = data_denied && !rvfi_i.trap;
    err_d.data_cause  = data_denied && is_exc && (rvfi_i.cause != data_cause_exp);

    // PMP CSRs are M-mode only, U-mode must see an exception
    err_d.csr_umode = is_pmp_csr_i && (rvfi_i.mode == pmp_pkg::U) && !is_exc;

    err_d.cfg_illegal = cfg_illegal_i;
    err_d.write_lost  = write_lost_i;
    err_d.lock_broken = lock_broken_i;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      err_o <= '0;
    end else if (rvfi_i.valid) begin
      err_o <= err_d;
    end else begin
      err_o <= '0;
    end
  end

  a_idle_no_err: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    !rvfi_i.valid |=> (err_o == '0)
  );

endmodule

//--- hw/pmp_rvfi_checker.sv
// ********************
// PMP checker on an RVFI-style retirement stream
// One retirement per cycle, err_o one cycle later
// ********************

`timescale 1ns/1ns

module pmp_rvfi_checker (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  pmp_pkg::rvfi_retire_t rvfi_i,
  input  pmp_pkg::pmp_csr_t     pmp_rdata_i,
  input  pmp_pkg::pmp_csr_t     pmp_wdata_i,
  input  pmp_pkg::pmp_csr_t     pmp_wmask_i,
  output pmp_pkg::pmp_err_t     err_o
);

  pmp_pkg::pmp_acc_e   data_acc;
  pmp_pkg::priv_mode_e data_priv;
  logic [11:0]         csr_num;
  logic [2:0]          funct3;
  logic                is_csr_instr;
  logic                is_mem;
  logic                is_pmp_csr;
  logic                instr_allowed;
  logic                data_allowed;
  logic                cfg_illegal;
  logic                write_lost;
  logic                lock_broken;

  // Loads and stores use MPP when MPRV is set
  assign data_priv = rvfi_i.mprv ? rvfi_i.mpp : rvfi_i.mode;
  assign data_acc  = (|rvfi_i.mem_wmask) ? pmp_pkg::WRITE : pmp_pkg::READ;
  assign is_mem    = |(rvfi_i.mem_rmask | rvfi_i.mem_wmask);

  assign funct3       = rvfi_i.insn[14:12];
  assign csr_num      = rvfi_i.insn[31:20];
  assign is_csr_instr = (rvfi_i.insn[6:0] == pmp_pkg::OPC_SYSTEM) &&
                        (funct3 != 3'd0) && (funct3 != 3'd4);

  assign is_pmp_csr = is_csr_instr &&
                      ((csr_num inside {[pmp_pkg::CSRADDR_PMPCFG0 : pmp_pkg::CSRADDR_PMPADDR0]}) ||
                       (csr_num inside {[pmp_pkg::CSRADDR_PMPADDR0 : pmp_pkg::CSRADDR_PMP_LAST]}) ||
                       (csr_num == pmp_pkg::CSRADDR_MSECCFG) ||
                       (csr_num == pmp_pkg::CSRADDR_MSECCFGH));

  pmp_region_match u_match_instr (
    .csr_i     (pmp_rdata_i),
    .addr_i    (rvfi_i.pc),
    .acc_i     (pmp_pkg::EXEC),
    .priv_i    (rvfi_i.mode),
    .allowed_o (instr_allowed)
  );

  pmp_region_match u_match_data (
    .csr_i     (pmp_rdata_i),
    .addr_i    (rvfi_i.mem_addr),
    .acc_i     (data_acc),
    .priv_i    (data_priv),
    .allowed_o (data_allowed)
  );

  pmp_cfg_legalize u_legalize (
    .rdata_i   (pmp_rdata_i),
    .wdata_i   (pmp_wdata_i),
    .wmask_i   (pmp_wmask_i),
    .illegal_o (cfg_illegal)
  );

  pmp_csr_history u_history (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .valid_i       (rvfi_i.valid),
    .rdata_i       (pmp_rdata_i),
    .wdata_i       (pmp_wdata_i),
    .wmask_i       (pmp_wmask_i),
    .write_lost_o  (write_lost),
    .lock_broken_o (lock_broken)
  );

  pmp_verdict u_verdict (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .rvfi_i          (rvfi_i),
    .is_mem_i        (is_mem),
    .is_pmp_csr_i    (is_pmp_csr),
    .instr_allowed_i (instr_allowed),
    .data_allowed_i  (data_allowed),
    .cfg_illegal_i   (cfg_illegal),
    .write_lost_i    (write_lost),
    .lock_broken_i   (lock_broken),
    .err_o           (err_o)
  );

  // Both matchers resolve fully on every retirement
  a_match_known: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    rvfi_i.valid |-> !$isunknown({instr_allowed, data_allowed})
  );

  // No cfg byte written means no legality finding
  a_unwritten_cfg_legal: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    rvfi_i.valid && (pmp_wmask_i.cfg == '0) |-> !cfg_illegal
  );

endmodule

//--- tb/tb_clk_gen.sv
// ********************
// 100 ns clock and active-low reset for the testbench
// Reset releases 10 ns after the fourth rising edge
// ********************

`timescale 1ns/1ns

module tb_clk_gen (
  output logic clk_o,
  output logic rst_no
);

  localparam int HALF_PERIOD  = 50;
  localparam int RESET_CYCLES = 4;
  localparam int REL_DELAY    = 10;

  initial begin
    clk_o = 1'b0;
    forever #HALF_PERIOD clk_o = ~clk_o;
  end

  initial begin
    rst_no = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    #REL_DELAY;
    rst_no = 1'b1;
  end

endmodule

//--- tb/tb_pmp_rvfi_checker.sv
// ********************
// Table-driven testbench for the PMP retirement checker
// Each row is one cycle, err_o is checked one cycle later
// Rows depend on each other through the CSR history
// ********************

`timescale 1ns/1ns

module tb_pmp_rvfi_checker;

  localparam int STIM_DELAY = 10;

  localparam logic [31:0] INSN_NOP        = 32'h0000_0013;
  localparam logic [31:0] INSN_CSRW_CFG0  = 32'h3A00_9073;
  localparam logic [31:0] INSN_CSRW_ADDR1 = 32'h3B10_9073;
  localparam logic [31:0] INSN_CSRW_ADDR3 = 32'h3B30_9073;
  // Word 0x440, inside region 1 once the TOR setup is in place
  localparam logic [31:0] PC_EXEC         = 32'h0000_1100;

  // Flag bits in pmp_err_t order, exec_notrap is the MSB
  localparam logic [7:0] E_NONE        = 8'h00;
  localparam logic [7:0] E_EXEC_NOTRAP = 8'h80;
  localparam logic [7:0] E_EXEC_CAUSE  = 8'h40;
  localparam logic [7:0] E_DATA_NOTRAP = 8'h20;
  localparam logic [7:0] E_DATA_CAUSE  = 8'h10;
  localparam logic [7:0] E_CSR_UMODE   = 8'h08;
  localparam logic [7:0] E_CFG_ILLEGAL = 8'h04;
  localparam logic [7:0] E_WRITE_LOST  = 8'h02;
  localparam logic [7:0] E_LOCK_BROKEN = 8'h01;

  typedef struct packed {
    pmp_pkg::rvfi_retire_t rvfi;
    pmp_pkg::pmp_csr_t     rdata;
    pmp_pkg::pmp_csr_t     wdata;
    pmp_pkg::pmp_csr_t     wmask;
    pmp_pkg::pmp_err_t     exp;
  } row_t;

  logic                  clk;
  logic                  rst_n;
  pmp_pkg::rvfi_retire_t rvfi;
  pmp_pkg::pmp_csr_t     pmp_rdata;
  pmp_pkg::pmp_csr_t     pmp_wdata;
  pmp_pkg::pmp_csr_t     pmp_wmask;
  pmp_pkg::pmp_err_t     err;

  row_t rows[$];
  int   limit_cycles = 0;
  int   cycle_cnt = 0;

  tb_clk_gen u_clk_gen (
    .clk_o  (clk),
    .rst_no (rst_n)
  );

  pmp_rvfi_checker dut_i (
    .clk_i       (clk),
    .rst_ni      (rst_n),
    .rvfi_i      (rvfi),
    .pmp_rdata_i (pmp_rdata),
    .pmp_wdata_i (pmp_wdata),
    .pmp_wmask_i (pmp_wmask),
    .err_o       (err)
  );

  function automatic pmp_pkg::rvfi_retire_t retire(logic [31:0] insn,
                                                   pmp_pkg::priv_mode_e mode,
                                                   logic [31:0] pc);
    pmp_pkg::rvfi_retire_t r;
    r = '0;
    r.valid = 1'b1;
    r.insn  = insn;
    r.mode  = mode;
    r.pc    = pc;
    return r;
  endfunction

  function automatic pmp_pkg::rvfi_retire_t mem_op(pmp_pkg::priv_mode_e mode,
                                                   logic [31:0] addr,
                                                   logic [3:0] rmask,
                                                   logic [3:0] wmask);
    pmp_pkg::rvfi_retire_t r;
    r = retire(INSN_NOP, mode, PC_EXEC);
    r.mem_addr  = addr;
    r.mem_rmask = rmask;
    r.mem_wmask = wmask;
    return r;
  endfunction

  function automatic pmp_pkg::rvfi_retire_t trapped(pmp_pkg::rvfi_retire_t r_in,
                                                    pmp_pkg::exc_cause_e cause);
    pmp_pkg::rvfi_retire_t r;
    r = r_in;
    r.trap      = 1'b1;
    r.exception = 1'b1;
    r.cause     = cause;
    return r;
  endfunction

  function automatic pmp_pkg::pmp_csr_t with_cfg(pmp_pkg::pmp_csr_t c_in, int idx,
                                                 logic [7:0] val);
    pmp_pkg::pmp_csr_t c;
    c = c_in;
    c.cfg[idx] = val;
    return c;
  endfunction

  function automatic pmp_pkg::pmp_csr_t with_addr(pmp_pkg::pmp_csr_t c_in, int idx,
                                                  logic [31:0] val);
    pmp_pkg::pmp_csr_t c;
    c = c_in;
    c.addr[idx] = val;
    return c;
  endfunction

  task automatic add_row(pmp_pkg::rvfi_retire_t r, pmp_pkg::pmp_csr_t rd,
                         pmp_pkg::pmp_csr_t wd, pmp_pkg::pmp_csr_t wm, logic [7:0] exp);
    row_t row;
    row.rvfi  = r;
    row.rdata = rd;
    row.wdata = wd;
    row.wmask = wm;
    row.exp   = exp;
    rows.push_back(row);
  endtask

  task automatic add_idle();
    add_row('0, '0, '0, '0, E_NONE);
  endtask

  task automatic build_table();
    pmp_pkg::pmp_csr_t     off;
    pmp_pkg::pmp_csr_t     s0;
    pmp_pkg::pmp_csr_t     s1;
    pmp_pkg::pmp_csr_t     s2;
    pmp_pkg::pmp_csr_t     s3;
    pmp_pkg::pmp_csr_t     s4;
    pmp_pkg::pmp_csr_t     s5;
    pmp_pkg::pmp_csr_t     cfg_all;
    pmp_pkg::rvfi_retire_t r;
    off = '0;
    cfg_all = '0;
    cfg_all.cfg = '1;
    // Region 0 TOR R-only below word 0x400, region 1 TOR X-only up to 0x800
    s0 = with_cfg(with_cfg(off, 0, 8'h09), 1, 8'h0C);
    s0 = with_addr(with_addr(s0, 0, 32'h400), 1, 32'h800);

    // All regions OFF
    add_row(mem_op(pmp_pkg::M, 32'h200, 4'hF, 4'h0), off, off, '0, E_NONE);
    add_row(retire(INSN_NOP, pmp_pkg::U, 32'h100), off, off, '0, E_EXEC_NOTRAP);
    add_row(trapped(retire(INSN_NOP, pmp_pkg::U, 32'h100), pmp_pkg::LOAD_ACC_FAULT),
            off, off, '0, E_EXEC_CAUSE);
    add_idle();
    add_row(retire(INSN_CSRW_CFG0, pmp_pkg::M, PC_EXEC), off, s0, '1, E_NONE);

    // Data accesses against the R-only TOR region
    add_row(mem_op(pmp_pkg::U, 32'h800, 4'h0, 4'hF), s0, s0, '0, E_DATA_NOTRAP);
    add_row(trapped(mem_op(pmp_pkg::U, 32'h800, 4'h0, 4'hF), pmp_pkg::STORE_ACC_FAULT),
            s0, s0, '0, E_NONE);
    add_row(trapped(mem_op(pmp_pkg::U, 32'h800, 4'h0, 4'hF), pmp_pkg::LOAD_ACC_FAULT),
            s0, s0, '0, E_DATA_CAUSE);
    r = mem_op(pmp_pkg::M, 32'h800, 4'h0, 4'hF);
    r.mprv = 1'b1;
    r.mpp  = pmp_pkg::U;
    add_row(r, s0, s0, '0, E_DATA_NOTRAP);
    add_row(mem_op(pmp_pkg::U, 32'h3000, 4'hF, 4'h0), s0, s0, '0, E_DATA_NOTRAP);
    add_row(mem_op(pmp_pkg::M, 32'h3000, 4'hF, 4'h0), s0, s0, '0, E_NONE);

    // PMP CSR access privilege
    add_row(retire(INSN_CSRW_CFG0, pmp_pkg::U, PC_EXEC), s0, s0, cfg_all, E_CSR_UMODE);
    add_row(retire(INSN_CSRW_CFG0, pmp_pkg::M, PC_EXEC), s0, s0, cfg_all, E_NONE);
    add_row(trapped(retire(INSN_CSRW_CFG0, pmp_pkg::U, PC_EXEC), pmp_pkg::ILLEGAL_INSTR),
            s0, s0, '0, E_NONE);

    // cfg legality, RW=01 then NA4 then a locked TOR entry
    s1 = with_cfg(s0, 2, 8'h02);
    add_row(retire(INSN_CSRW_CFG0, pmp_pkg::M, PC_EXEC), s0, s1, with_cfg('0, 2, 8'hFF),
            E_CFG_ILLEGAL);
    s2 = with_cfg(s1, 3, 8'h11);
    add_row(retire(INSN_CSRW_CFG0, pmp_pkg::M, PC_EXEC), s1, s2, with_cfg('0, 3, 8'hFF),
            E_CFG_ILLEGAL);
    s3 = with_addr(with_cfg(s2, 2, 8'h89), 2, 32'hC00);
    add_row(retire(INSN_CSRW_CFG0, pmp_pkg::M, PC_EXEC), s2, s3,
            with_addr(with_cfg('0, 2, 8'hFF), 2, '1), E_NONE);
    add_row(retire(INSN_CSRW_CFG0, pmp_pkg::M, PC_EXEC), s3, with_cfg(s3, 2, 8'h8B),
            with_cfg('0, 2, 8'hFF), E_CFG_ILLEGAL);
    // Locked entry held, so the reported write never lands
    add_row(retire(INSN_NOP, pmp_pkg::M, PC_EXEC), s3, s3, '0, E_WRITE_LOST);

    // History across retirements
    add_row(retire(INSN_CSRW_ADDR3, pmp_pkg::M, PC_EXEC), s3, with_addr(s3, 3, 32'h1000),
            with_addr('0, 3, '1), E_NONE);
    add_row(retire(INSN_NOP, pmp_pkg::M, PC_EXEC), s3, s3, '0, E_WRITE_LOST);
    s4 = with_addr(s3, 1, 32'h900);
    add_row(retire(INSN_CSRW_ADDR1, pmp_pkg::M, PC_EXEC), s3, s4, with_addr('0, 1, '1),
            E_NONE);
    add_idle();
    add_idle();
    // Address below the locked TOR region 2 moved
    add_row(retire(INSN_NOP, pmp_pkg::M, PC_EXEC), s4, s4, '0, E_LOCK_BROKEN);
    s5 = with_addr(s4, 2, 32'hD00);
    add_row(retire(INSN_NOP, pmp_pkg::M, PC_EXEC), s5, s5, '0,
            E_LOCK_BROKEN | E_WRITE_LOST);
    add_idle();
  endtask

  task automatic apply_row(row_t row);
    rvfi      = row.rvfi;
    pmp_rdata = row.rdata;
    pmp_wdata = row.wdata;
    pmp_wmask = row.wmask;
  endtask

  always @(posedge clk) begin
    cycle_cnt = cycle_cnt + 1;
    if ((limit_cycles != 0) && (cycle_cnt >= limit_cycles)) begin
      $display("Timeout after %0d cycles, the row loop did not complete", cycle_cnt);
      $display("TEST FAILED");
      $fatal(1, "run stopped by timeout");
    end
  end

  initial begin
    rvfi      = '0;
    pmp_rdata = '0;
    pmp_wdata = '0;
    pmp_wmask = '0;
    build_table();
    limit_cycles = rows.size() * 2 + 20;

    @(posedge rst_n);
    for (int i = 0; i < rows.size(); i++) begin
      apply_row(rows[i]);
      @(posedge clk);
      #STIM_DELAY;
      assert (err === rows[i].exp) else begin
        $display("MISMATCH row %0d err_o: got %h expected %h", i, err, rows[i].exp);
        $display("TEST FAILED");
        $fatal(1, "wrong error flags");
      end
    end

    $display("TEST PASSED");
    $finish;
  end

endmodule

//--- flist.f
hw/pmp_pkg.sv
hw/pmp_region_match.sv
hw/pmp_cfg_legalize.sv
hw/pmp_csr_history.sv
hw/pmp_verdict.sv
hw/pmp_rvfi_checker.sv
tb/tb_clk_gen.sv
tb/tb_pmp_rvfi_checker.sv
